// File: Makefile
SIM    ?= verilator
TOP    ?= tb_rsa_top
VFLAGS ?= --binary -Wno-fatal
MDIR   ?= obj_dir

SRCS := $(shell grep -v '^+' tb.f)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) tb.f
	$(SIM) $(VFLAGS) -f tb.f --top-module $(TOP) -Mdir $(MDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf $(MDIR)

// File: mont_mul.sv
`timescale 1ns/1ps

module mont_mul #(
	parameter int BITWIDTH = 256
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  logic [BITWIDTH-1:0] i_mod,
	input  logic [BITWIDTH-1:0] i_a,
	input  logic [BITWIDTH-1:0] i_b,
	output logic                o_done,
	output logic [BITWIDTH-1:0] o_result
);

	localparam int CW = $clog2(BITWIDTH);
	localparam logic [CW-1:0] LAST = CW'(BITWIDTH - 1);

	rsa_fsm_pkg::mont_state_e state_r;
	logic [CW-1:0]       iter_r;
	logic [BITWIDTH-1:0] a_r;     // multiplier, consumed lsb first
	logic [BITWIDTH-1:0] b_r;
	logic [BITWIDTH+1:0] acc_r;   // stays below 2n between steps
	logic [BITWIDTH+1:0] sum_ab;
	logic [BITWIDTH+1:0] sum_n;   // below 4n, hence two guard bits
	logic [BITWIDTH+1:0] acc_sub;

	// one radix-2 step
	always_comb begin
		sum_ab  = acc_r + (a_r[0] ? {2'b00, b_r} : '0);
		sum_n   = sum_ab + (sum_ab[0] ? {2'b00, i_mod} : '0); // make it even
		acc_sub = acc_r - {2'b00, i_mod};
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= rsa_fsm_pkg::MM_IDLE;
			iter_r  <= '0;
			o_done  <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state_r)
				rsa_fsm_pkg::MM_IDLE: begin
					if (i_start) begin
						state_r <= rsa_fsm_pkg::MM_ITER;
						iter_r  <= '0;
					end
				end
				rsa_fsm_pkg::MM_ITER: begin
					iter_r <= iter_r + 1'b1;
					if (iter_r == LAST)
						state_r <= rsa_fsm_pkg::MM_FIX;
				end
				rsa_fsm_pkg::MM_FIX: begin
					o_done  <= 1'b1; // lines up with o_result
					state_r <= rsa_fsm_pkg::MM_IDLE;
				end
				default: state_r <= rsa_fsm_pkg::MM_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		case (state_r)
			rsa_fsm_pkg::MM_IDLE: begin
				if (i_start) begin
					a_r   <= i_a;
					b_r   <= i_b;
					acc_r <= '0;
				end
			end
			rsa_fsm_pkg::MM_ITER: begin
				a_r   <= a_r >> 1;
				acc_r <= sum_n >> 1;
			end
			rsa_fsm_pkg::MM_FIX: begin
				// final subtraction brings the result below n
				if (acc_r >= {2'b00, i_mod})
					o_result <= acc_sub[BITWIDTH-1:0];
				else
					o_result <= acc_r[BITWIDTH-1:0];
			end
			default: ;
		endcase
	end

endmodule

// File: rsa_bus_pkg.sv
package rsa_bus_pkg;

	// width of one bus word
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// which operand register a bus write goes to
	typedef logic [1:0] opsel_t;

	localparam opsel_t SEL_N = 2'd0; // modulus
	localparam opsel_t SEL_D = 2'd1; // exponent
	localparam opsel_t SEL_A = 2'd2; // base

	// selector 3 is reserved, writes to it are dropped

endpackage

// File: rsa_fsm_pkg.sv
package rsa_fsm_pkg;

	// exponentiation controller
	typedef enum logic [2:0] {
		S_IDLE,
		S_SHIFT,  // a into montgomery domain
		S_SCAN,   // look at next exponent bit
		S_MULT,   // m = mont(m, t)
		S_SQUARE  // t = mont(t, t)
	} modexp_state_e;

	// montgomery multiplier
	typedef enum logic [1:0] {
		MM_IDLE,
		MM_ITER,
		MM_FIX
	} mont_state_e;

endpackage

// File: rsa_modexp.sv
`timescale 1ns/1ps

module rsa_modexp #(
	parameter int BITWIDTH = 256
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  logic [BITWIDTH-1:0] i_n,
	input  logic [BITWIDTH-1:0] i_d,
	input  logic [BITWIDTH-1:0] i_a,
	input  logic                i_out_done,
	output logic                o_busy,
	output logic                o_done,
	output logic [BITWIDTH-1:0] o_result
);

	localparam int CW = $clog2(BITWIDTH);
	localparam logic [CW-1:0] LAST = CW'(BITWIDTH - 1);

	rsa_fsm_pkg::modexp_state_e state_r;
	logic [CW-1:0]       bit_r;      // doubling count, then exponent bit index
	logic                busy_r;
	logic [BITWIDTH-1:0] t_r;        // a * 2^k in montgomery form
	logic [BITWIDTH-1:0] m_r;        // running result, normal domain
	logic                mm_start_r;
	logic [BITWIDTH-1:0] mm_a_r;
	logic [BITWIDTH-1:0] mm_b_r;
	logic                mm_done;
	logic [BITWIDTH-1:0] mm_result;
	logic [BITWIDTH:0]   dbl;
	logic [BITWIDTH:0]   dbl_sub;
	logic                start_ok;

	assign start_ok = i_start && !busy_r;
	assign dbl      = {t_r, 1'b0};
	assign dbl_sub  = dbl - {1'b0, i_n};
	assign o_busy   = busy_r;
	assign o_result = m_r; // final once o_done pulses

	mont_mul #(
		.BITWIDTH(BITWIDTH)
	) u_mont_mul (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_start  (mm_start_r),
		.i_mod    (i_n),
		.i_a      (mm_a_r),
		.i_b      (mm_b_r),
		.o_done   (mm_done),
		.o_result (mm_result)
	);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r    <= rsa_fsm_pkg::S_IDLE;
			bit_r      <= '0;
			busy_r     <= 1'b0;
			mm_start_r <= 1'b0;
			o_done     <= 1'b0;
		end else begin
			mm_start_r <= 1'b0;
			o_done     <= 1'b0;
			case (state_r)
				rsa_fsm_pkg::S_IDLE: begin
					if (start_ok) begin
						busy_r  <= 1'b1;
						bit_r   <= '0;
						state_r <= rsa_fsm_pkg::S_SHIFT;
					end
				end
				rsa_fsm_pkg::S_SHIFT: begin
					if (bit_r == LAST) begin
						bit_r   <= '0;
						state_r <= rsa_fsm_pkg::S_SCAN;
					end else begin
						bit_r <= bit_r + 1'b1;
					end
				end
				rsa_fsm_pkg::S_SCAN: begin
					mm_start_r <= 1'b1;
					state_r    <= i_d[bit_r] ? rsa_fsm_pkg::S_MULT : rsa_fsm_pkg::S_SQUARE;
				end
				rsa_fsm_pkg::S_MULT: begin
					if (mm_done) begin
						mm_start_r <= 1'b1; // square always follows a multiply
						state_r    <= rsa_fsm_pkg::S_SQUARE;
					end
				end
				rsa_fsm_pkg::S_SQUARE: begin
					if (mm_done) begin
						if (bit_r == LAST) begin
							o_done  <= 1'b1;
							state_r <= rsa_fsm_pkg::S_IDLE;
						end else begin
							bit_r   <= bit_r + 1'b1;
							state_r <= rsa_fsm_pkg::S_SCAN;
						end
					end
				end
				default: state_r <= rsa_fsm_pkg::S_IDLE;
			endcase
			// busy spans until the serializer has sent its last word
			if (i_out_done)
				busy_r <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		case (state_r)
			rsa_fsm_pkg::S_IDLE: begin
				if (start_ok) begin
					t_r <= i_a;
					m_r <= BITWIDTH'(1);
				end
			end
			rsa_fsm_pkg::S_SHIFT: begin
				// t = 2t mod n, a < n keeps one subtract enough
				if (dbl >= {1'b0, i_n})
					t_r <= dbl_sub[BITWIDTH-1:0];
				else
					t_r <= dbl[BITWIDTH-1:0];
			end
			rsa_fsm_pkg::S_SCAN: begin
				mm_a_r <= i_d[bit_r] ? m_r : t_r;
				mm_b_r <= t_r;
			end
			rsa_fsm_pkg::S_MULT: begin
				if (mm_done) begin
					m_r    <= mm_result; // t carries the R factor, m stays normal
					mm_a_r <= t_r;
					mm_b_r <= t_r;
				end
			end
			rsa_fsm_pkg::S_SQUARE: begin
				if (mm_done)
					t_r <= mm_result;
			end
			default: ;
		endcase
	end

endmodule

// File: rsa_operand_loader.sv
`timescale 1ns/1ps

module rsa_operand_loader #(
	parameter int BITWIDTH = 256
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_wr,
	input  rsa_bus_pkg::opsel_t   i_sel,
	input  rsa_bus_pkg::word_t    i_word,
	input  logic                  i_busy,
	output logic [BITWIDTH-1:0]   o_n,
	output logic [BITWIDTH-1:0]   o_d,
	output logic [BITWIDTH-1:0]   o_a
);

	logic [BITWIDTH-1:0] n_r;
	logic [BITWIDTH-1:0] d_r;
	logic [BITWIDTH-1:0] a_r;
	logic [BITWIDTH-1:0] word_ext; // bus word placed at the low end
	logic                take;

	assign word_ext = BITWIDTH'(i_word);
	assign take     = i_wr && !i_busy; // core needs stable operands

	// words arrive msw first, so each write pushes older words up
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			n_r <= '0;
			d_r <= '0;
			a_r <= '0;
		end else if (take) begin
			case (i_sel)
				rsa_bus_pkg::SEL_N: n_r <= (n_r << rsa_bus_pkg::WORD_W) | word_ext;
				rsa_bus_pkg::SEL_D: d_r <= (d_r << rsa_bus_pkg::WORD_W) | word_ext;
				rsa_bus_pkg::SEL_A: a_r <= (a_r << rsa_bus_pkg::WORD_W) | word_ext;
				default: ; // reserved selector
			endcase
		end
	end

	// contents survive an operation, a repeat start reuses them
	assign o_n = n_r;
	assign o_d = d_r;
	assign o_a = a_r;

endmodule

// File: rsa_result_serializer.sv
`timescale 1ns/1ps

module rsa_result_serializer #(
	parameter int BITWIDTH = 256
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_load,
	input  logic [BITWIDTH-1:0]  i_result,
	output logic                 o_valid,
	output logic                 o_last,
	output rsa_bus_pkg::word_t   o_word,
	output logic                 o_drained
);

	localparam int NW = BITWIDTH / rsa_bus_pkg::WORD_W;
	localparam int CW = (NW > 1) ? $clog2(NW) : 1;
	localparam logic [CW-1:0] LAST_IDX = CW'(NW - 1);

	logic [CW-1:0]       left_r; // words still to follow the current one
	logic [BITWIDTH-1:0] sh_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
			left_r  <= '0;
		end else if (i_load) begin
			o_valid <= 1'b1;
			left_r  <= LAST_IDX;
		end else if (o_valid) begin
			if (left_r == '0)
				o_valid <= 1'b0;
			else
				left_r <= left_r - 1'b1;
		end
	end

	// msw sits at the top, shift up after each word
	always_ff @(posedge i_clk) begin
		if (i_load)
			sh_r <= i_result;
		else if (o_valid)
			sh_r <= sh_r << rsa_bus_pkg::WORD_W;
	end

	assign o_word    = sh_r[BITWIDTH-1 -: rsa_bus_pkg::WORD_W];
	assign o_last    = o_valid && (left_r == '0);
	assign o_drained = o_last; // lets the core drop busy
endmodule

// File: rsa_stim.txt
// columns: reload disturb n d a expected, all hex, one vector per line
// reload 0 reuses the held operands, disturb 1 pokes start and writes while busy
1 0 00000000000000BB 0000000000000007 0000000000000058 000000000000000B
1 0 00000000000000BB 0000000000000017 000000000000000B 0000000000000058
1 0 FFFFFFFFFFFFFFC5 0000000000000001 DEADBEEFCAFEF00D DEADBEEFCAFEF00D
1 0 FFFFFFFFFFFFFFC5 0000000000000000 DEADBEEFCAFEF00D 0000000000000001
1 1 FFFFFFFFFFFFFFC5 FFFFFFFFFFFFFFC4 0000000000000002 0000000000000001
1 0 1FFFFFFFFFFFFFFF 1FFFFFFFFFFFFFFF 0123456789ABCDEF 0123456789ABCDEF
0 0 1FFFFFFFFFFFFFFF 1FFFFFFFFFFFFFFF 0123456789ABCDEF 0123456789ABCDEF
1 1 00000000000000BB 0000000000000007 0000000000000058 000000000000000B
0 1 00000000000000BB 0000000000000007 0000000000000058 000000000000000B

// File: rsa_top.sv
`timescale 1ns/1ps

module rsa_top #(
	parameter int BITWIDTH = 256
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_wr,
	input  rsa_bus_pkg::opsel_t  i_sel,
	input  rsa_bus_pkg::word_t   i_word,
	input  logic                 i_start,
	output logic                 o_busy,
	output logic                 o_valid,
	output logic                 o_last,
	output rsa_bus_pkg::word_t   o_word
);

	logic [BITWIDTH-1:0] op_n;
	logic [BITWIDTH-1:0] op_d;
	logic [BITWIDTH-1:0] op_a;
	logic [BITWIDTH-1:0] exp_result;
	logic                exp_done;
	logic                out_drained;

	rsa_operand_loader #(
		.BITWIDTH(BITWIDTH)
	) u_loader (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (i_wr),
		.i_sel   (i_sel),
		.i_word  (i_word),
		.i_busy  (o_busy),
		.o_n     (op_n),
		.o_d     (op_d),
		.o_a     (op_a)
	);

	rsa_modexp #(
		.BITWIDTH(BITWIDTH)
	) u_modexp (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_n        (op_n),
		.i_d        (op_d),
		.i_a        (op_a),
		.i_out_done (out_drained),
		.o_busy     (o_busy),
		.o_done     (exp_done),
		.o_result   (exp_result)
	);

	rsa_result_serializer #(
		.BITWIDTH(BITWIDTH)
	) u_serializer (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_load    (exp_done),
		.i_result  (exp_result),
		.o_valid   (o_valid),
		.o_last    (o_last),
		.o_word    (o_word),
		.o_drained (out_drained)
	);

endmodule

// File: tb.f
rsa_bus_pkg.sv
rsa_fsm_pkg.sv
rsa_operand_loader.sv
mont_mul.sv
rsa_modexp.sv
rsa_result_serializer.sv
rsa_top.sv
tb_rsa_top.sv

// File: tb_rsa_top.sv
`timescale 1ns/1ps

module tb_rsa_top;

	localparam int BITWIDTH    = 64;
	localparam int NW          = BITWIDTH / rsa_bus_pkg::WORD_W;
	localparam int MAX_TESTS   = 32;
	localparam int FIELDS      = 6; // reload, disturb, n, d, a, expected
	localparam int TEST_CYCLES = BITWIDTH + BITWIDTH * 2 * (BITWIDTH + 3) + 64;

	logic                i_clk;
	logic                i_rst_n;
	logic                i_wr;
	rsa_bus_pkg::opsel_t i_sel;
	rsa_bus_pkg::word_t  i_word;
	logic                i_start;
	logic                o_busy;
	logic                o_valid;
	logic                o_last;
	rsa_bus_pkg::word_t  o_word;

	logic [BITWIDTH-1:0] stim_mem [0:MAX_TESTS*FIELDS-1];
	logic [31:0]         lcg_state = 32'd28403;
	int num_tests   = 0;
	int test_errs   = 0;
	int pass_cnt    = 0;
	int fail_cnt    = 0;
	int cycle_cnt   = 0;
	int cycle_limit = 100000; // replaced once the vectors are counted

	rsa_top #(
		.BITWIDTH(BITWIDTH)
	) uut (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (i_wr),
		.i_sel   (i_sel),
		.i_word  (i_word),
		.i_start (i_start),
		.o_busy  (o_busy),
		.o_valid (o_valid),
		.o_last  (o_last),
		.o_word  (o_word)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// watchdog
	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: no complete result after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	task automatic check_word(input string name, input rsa_bus_pkg::word_t got,
			input rsa_bus_pkg::word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			test_errs = test_errs + 1;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			test_errs = test_errs + 1;
		end
	endtask

	// msw first with random idle gaps between words
	task automatic write_operand(input rsa_bus_pkg::opsel_t sel, input logic [BITWIDTH-1:0] val);
		int gap;
		for (int w = NW - 1; w >= 0; w--) begin
			@(posedge i_clk);
			i_wr   <= 1'b1;
			i_sel  <= sel;
			i_word <= val[w*rsa_bus_pkg::WORD_W +: rsa_bus_pkg::WORD_W];
			@(posedge i_clk);
			i_wr <= 1'b0;
			gap = int'(next_random()) % 3;
			repeat (gap) @(posedge i_clk);
		end
	endtask

	// start plus writes to every selector while the core is busy
	task automatic disturb_busy();
		int delay;
		delay = int'(next_random()) % (2 * BITWIDTH);
		repeat (delay) @(posedge i_clk);
		for (int s = 0; s < 4; s++) begin
			i_start <= (s == 0);
			i_wr    <= 1'b1;
			i_sel   <= rsa_bus_pkg::opsel_t'(s);
			i_word  <= next_random();
			@(posedge i_clk);
		end
		i_wr <= 1'b0;
	endtask

	task automatic run_vector(input int idx);
		logic [BITWIDTH-1:0] n_val;
		logic [BITWIDTH-1:0] d_val;
		logic [BITWIDTH-1:0] a_val;
		logic [BITWIDTH-1:0] expect_val;
		logic                reload;
		logic                disturb;
		rsa_bus_pkg::word_t  exp_word;
		reload     = stim_mem[idx*FIELDS][0];
		disturb    = stim_mem[idx*FIELDS+1][0];
		n_val      = stim_mem[idx*FIELDS+2];
		d_val      = stim_mem[idx*FIELDS+3];
		a_val      = stim_mem[idx*FIELDS+4];
		expect_val = stim_mem[idx*FIELDS+5];
		test_errs  = 0;
		if (reload) begin
			write_operand(rsa_bus_pkg::SEL_N, n_val);
			write_operand(rsa_bus_pkg::SEL_D, d_val);
			write_operand(rsa_bus_pkg::SEL_A, a_val);
		end
		@(posedge i_clk);
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
		@(posedge i_clk);
		check_bit("o_busy", o_busy, 1'b1);
		if (disturb)
			disturb_busy();
		while (o_valid !== 1'b1)
			@(posedge i_clk);
		for (int w = 0; w < NW; w++) begin
			exp_word = expect_val[(NW-1-w)*rsa_bus_pkg::WORD_W +: rsa_bus_pkg::WORD_W];
			check_bit("o_valid", o_valid, 1'b1);
			check_word("o_word", o_word, exp_word);
			if (w < NW - 1) begin
				check_bit("o_last", o_last, 1'b0);
			end else if (o_last !== 1'b1) begin
				$display("test %0d: o_last did not come with the final word", idx + 1);
				test_errs = test_errs + 1;
			end
			@(posedge i_clk);
		end
		check_bit("o_valid", o_valid, 1'b0); // no extra word
		check_bit("o_busy", o_busy, 1'b0);
		if (test_errs == 0) begin
			$display("test %0d (d=%h a=%h): ok", idx + 1, d_val, a_val);
			pass_cnt = pass_cnt + 1;
		end else begin
			$display("test %0d (d=%h a=%h): %0d mismatches", idx + 1, d_val, a_val, test_errs);
			fail_cnt = fail_cnt + 1;
		end
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_wr    = 1'b0;
		i_sel   = '0;
		i_word  = '0;
		i_start = 1'b0;
		for (int i = 0; i < MAX_TESTS * FIELDS; i++)
			stim_mem[i] = ~BITWIDTH'(i); // unwritten slots hold a value no flag can take
		$readmemh("rsa_stim.txt", stim_mem);
		while (num_tests < MAX_TESTS && stim_mem[num_tests*FIELDS] <= 1)
			num_tests = num_tests + 1;
		cycle_limit = (num_tests + 1) * TEST_CYCLES + 500;

		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// outputs must stay quiet until the first start
		test_errs = 0;
		repeat (4) begin
			@(posedge i_clk);
			check_bit("o_valid", o_valid, 1'b0);
			check_bit("o_last", o_last, 1'b0);
			check_bit("o_busy", o_busy, 1'b0);
		end
		if (test_errs == 0) begin
			$display("test 0 (reset state): ok");
			pass_cnt = pass_cnt + 1;
		end else begin
			$display("test 0 (reset state): %0d mismatches", test_errs);
			fail_cnt = fail_cnt + 1;
		end

		if (num_tests == 0) begin
			$display("no test vectors found in rsa_stim.txt");
			fail_cnt = fail_cnt + 1;
		end
		for (int t = 0; t < num_tests; t++)
			run_vector(t);

		$display("%0d tests run, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
